// ==== rf_pkg.sv ====
////////////////////////////////////////
// Register file package
// Widths, typedefs and clear sequencer states
////////////////////////////////////////

package rf_pkg;

    ////////////////////////////////////////
    // Sizes

    // Default data width, overridden from the top level
    parameter int XLEN = 32;

    // Architectural register count, x0 included
    parameter int NUM_REGS = 32;

    // Default instruction id width
    parameter int ID_W = 3;

    // Register index width
    parameter int ADDR_W = $clog2(NUM_REGS);

    ////////////////////////////////////////
    // Types

    // Register index
    typedef logic [ADDR_W-1:0] reg_addr_t;

    // Register value at the default width
    typedef logic [XLEN-1:0] reg_data_t;

    // Instruction id at the default width
    typedef logic [ID_W-1:0] instr_id_t;

    // Clear sequencer states
    // CLR_ALL walks the whole file, CLR_INUSE only the scoreboard
    typedef enum logic [1:0] {
        CLR_ALL,
        CLR_INUSE,
        READY
    } clr_state_t;

endpackage

// ==== rf_clear_counter.sv ====
////////////////////////////////////////
// Clear index counter
// Walks every register entry once per clear
////////////////////////////////////////

module rf_clear_counter (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clr_start,
    output rf_pkg::reg_addr_t clr_idx,
    output logic              clr_active,
    output logic              clr_done
);
    import rf_pkg::*;

    // Index of the final entry
    localparam reg_addr_t LAST_IDX = reg_addr_t'(NUM_REGS - 1);

    // One entry per cycle while active
    // Done is a single pulse after the last entry is written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clr_idx    <= '0;
            clr_active <= 1'b0;
            clr_done   <= 1'b0;
        end else begin
            clr_done <= 1'b0;
            if (clr_start) begin
                // Restart from entry zero
                clr_idx    <= '0;
                clr_active <= 1'b1;
            end else if (clr_active) begin
                if (clr_idx == LAST_IDX) begin
                    // Last entry cleared this edge
                    clr_active <= 1'b0;
                    clr_done   <= 1'b1;
                end else begin
                    clr_idx <= clr_idx + 1'b1;
                end
            end
        end
    end

endmodule

// ==== rf_init_fsm.sv ====
////////////////////////////////////////
// Clear sequencer FSM
// Full clear after reset, scoreboard clear on flush
////////////////////////////////////////

module rf_init_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic flush,
    input  logic clr_done,
    output logic clr_start,
    output logic clr_all,
    output logic ready
);
    import rf_pkg::*;

    clr_state_t state_q;
    clr_state_t state_d;

    // Start request left over from reset
    logic start_q;

    // Flush taken only while idle
    logic flush_go;

    assign flush_go = flush & (state_q == READY);

    ////////////////////////////////////////
    // Next state

    always_comb begin
        state_d = state_q;
        case (state_q)
            CLR_ALL, CLR_INUSE: begin
                // Counter reports the last entry
                if (clr_done) begin
                    state_d = READY;
                end
            end
            READY: begin
                if (flush) begin
                    state_d = CLR_INUSE;
                end
            end
            default: begin
                state_d = CLR_ALL;
            end
        endcase
    end

    ////////////////////////////////////////
    // State and ready flops

    // Reset lands in CLR_ALL with a start already pending
    // Ready tracks the next state so it falls with the flush edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= CLR_ALL;
            start_q <= 1'b1;
            ready   <= 1'b0;
        end else begin
            state_q <= state_d;
            start_q <= 1'b0;
            ready   <= (state_d == READY);
        end
    end

    // Counter load on entry to either clear state
    assign clr_start = start_q | flush_go;

    // Register values and owner ids only in the full clear
    assign clr_all = (state_q == CLR_ALL);

endmodule

// ==== rf_inuse.sv ====
////////////////////////////////////////
// Scoreboard in-use table
// One pending-result bit per register
////////////////////////////////////////

module rf_inuse (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clr_active,
    input  rf_pkg::reg_addr_t clr_idx,
    input  logic              ready,
    input  logic              issue,
    input  rf_pkg::reg_addr_t issue_rd,
    input  logic              wb_match,
    input  rf_pkg::reg_addr_t wb_rd,
    input  rf_pkg::reg_addr_t rs1_addr,
    input  rf_pkg::reg_addr_t rs2_addr,
    output logic              rs1_inuse,
    output logic              rs2_inuse
);
    import rf_pkg::*;

    logic [NUM_REGS-1:0] inuse_q;

    // Accepted issue with a real destination
    logic set_en;

    assign set_en = ready & issue & (issue_rd != '0);

    ////////////////////////////////////////
    // Table update

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inuse_q <= '0;
        end else if (clr_active) begin
            // Sequenced clear, one entry per cycle
            inuse_q[clr_idx] <= 1'b0;
        end else begin
            // Completion by the owning id
            if (wb_match) begin
                inuse_q[wb_rd] <= 1'b0;
            end
            // Issue comes last so it wins on the same register
            if (set_en) begin
                inuse_q[issue_rd] <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Source lookup

    // x0 never waits on anything
    assign rs1_inuse = (rs1_addr != '0) & inuse_q[rs1_addr];
    assign rs2_inuse = (rs2_addr != '0) & inuse_q[rs2_addr];

endmodule

// ==== rf_regs.sv ====
////////////////////////////////////////
// Register storage and owner ids
// Writeback bypass and source conflict detect
////////////////////////////////////////

module rf_regs #(
    parameter int XLEN = rf_pkg::XLEN,
    parameter int ID_W = rf_pkg::ID_W
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clr_active,
    input  logic              clr_all,
    input  rf_pkg::reg_addr_t clr_idx,
    input  logic              ready,
    input  logic              issue,
    input  rf_pkg::reg_addr_t issue_rd,
    input  logic [ID_W-1:0]   issue_id,
    input  logic              wb_commit,
    input  rf_pkg::reg_addr_t wb_rd,
    input  logic [ID_W-1:0]   wb_id,
    input  logic [XLEN-1:0]   wb_data,
    input  rf_pkg::reg_addr_t rs1_addr,
    input  rf_pkg::reg_addr_t rs2_addr,
    input  logic              uses_rs1,
    input  logic              uses_rs2,
    input  logic              rs1_inuse,
    input  logic              rs2_inuse,
    input  rf_pkg::reg_addr_t dbg_addr,
    output logic [XLEN-1:0]   dbg_data,
    output logic              wb_match,
    output logic [XLEN-1:0]   rs1_data,
    output logic [XLEN-1:0]   rs2_data,
    output logic              rs1_conflict,
    output logic              rs2_conflict
);
    import rf_pkg::*;

    // Architectural values
    logic [XLEN-1:0] regs [NUM_REGS];

    // Id of the youngest writer of each register
    logic [ID_W-1:0] owner [NUM_REGS];

    logic full_clr;
    logic wr_en;
    logic own_en;
    logic rs1_fwd;
    logic rs2_fwd;

    // Full clear touches values and owners
    assign full_clr = clr_active & clr_all;

    // Commits outside a clear, x0 stays zero
    assign wr_en = ready & wb_commit & (wb_rd != '0);

    // Owner recorded for accepted issues only
    assign own_en = ready & issue & (issue_rd != '0);

    ////////////////////////////////////////
    // Storage

    always_ff @(posedge clk) begin
        if (full_clr) begin
            regs[clr_idx] <= '0;
        end else if (wr_en) begin
            // Stale ids still write the value
            regs[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                owner[i] <= '0;
            end
        end else if (full_clr) begin
            owner[clr_idx] <= '0;
        end else if (own_en) begin
            owner[issue_rd] <= issue_id;
        end
    end

    // Only the owning id retires the scoreboard entry
    assign wb_match = wr_en & (wb_id == owner[wb_rd]);

    ////////////////////////////////////////
    // Decode read and bypass

    // Result arriving this cycle for a waiting source
    assign rs1_fwd = rs1_inuse & wb_match & (wb_rd == rs1_addr);
    assign rs2_fwd = rs2_inuse & wb_match & (wb_rd == rs2_addr);

    assign rs1_data = rs1_fwd ? wb_data : regs[rs1_addr];
    assign rs2_data = rs2_fwd ? wb_data : regs[rs2_addr];

    // Stall only a used source still waiting, and never during a clear
    assign rs1_conflict = ready & uses_rs1 & rs1_inuse & ~rs1_fwd;
    assign rs2_conflict = ready & uses_rs2 & rs2_inuse & ~rs2_fwd;

    // Debug port view of the stored value
    assign dbg_data = regs[dbg_addr];

endmodule

// ==== rf_wb_debug.sv ====
////////////////////////////////////////
// Wishbone classic debug slave
// Read-only view of the register file
////////////////////////////////////////

module rf_wb_debug #(
    parameter int XLEN = rf_pkg::XLEN
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  rf_pkg::reg_addr_t wb_adr,
    output logic [XLEN-1:0]   wb_dat_o,
    output logic              wb_ack,
    output rf_pkg::reg_addr_t dbg_addr,
    input  logic [XLEN-1:0]   dbg_data
);

    // New request, blocked in the ack cycle
    logic req;

    assign req = wb_cyc & wb_stb & ~wb_ack;

    // Address goes straight to the storage read port
    assign dbg_addr = wb_adr;

    ////////////////////////////////////////
    // Ack

    // One-cycle ack, one edge after the request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    ////////////////////////////////////////
    // Read data

    // Captured for reads only
    // Writes get an ack and change nothing
    always_ff @(posedge clk) begin
        if (req & ~wb_we) begin
            wb_dat_o <= dbg_data;
        end
    end

endmodule

// ==== rf_core_top.sv ====
////////////////////////////////////////
// Register file with scoreboard
// Sequencer, storage and Wishbone debug port
////////////////////////////////////////

module rf_core_top #(
    parameter int XLEN = rf_pkg::XLEN,
    parameter int ID_W = rf_pkg::ID_W
) (
    input  logic              clk,
    input  logic              rst_n,
    // Decode side
    input  rf_pkg::reg_addr_t rs1_addr,
    input  rf_pkg::reg_addr_t rs2_addr,
    input  logic              uses_rs1,
    input  logic              uses_rs2,
    input  logic              issue,
    input  rf_pkg::reg_addr_t issue_rd,
    input  logic [ID_W-1:0]   issue_id,
    output logic [XLEN-1:0]   rs1_data,
    output logic [XLEN-1:0]   rs2_data,
    output logic              rs1_conflict,
    output logic              rs2_conflict,
    output logic              ready,
    // Writeback side
    input  logic              wb_commit,
    input  rf_pkg::reg_addr_t wb_rd,
    input  logic [ID_W-1:0]   wb_id,
    input  logic [XLEN-1:0]   wb_data,
    input  logic              flush,
    // Wishbone debug
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  rf_pkg::reg_addr_t wb_adr,
    output logic [XLEN-1:0]   wb_dat_o,
    output logic              wb_ack
);
    import rf_pkg::*;

    // Sequencer to counter
    logic clr_start;
    logic clr_all;
    logic clr_done;

    // Counter to tables
    reg_addr_t clr_idx;
    logic      clr_active;

    // Scoreboard and storage
    logic rs1_inuse;
    logic rs2_inuse;
    logic wb_match;

    // Debug read port
    reg_addr_t       dbg_addr;
    logic [XLEN-1:0] dbg_data;

    ////////////////////////////////////////
    // Clear control

    rf_init_fsm init_fsm_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .clr_done  (clr_done),
        .clr_start (clr_start),
        .clr_all   (clr_all),
        .ready     (ready)
    );

    rf_clear_counter clear_counter_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .clr_start  (clr_start),
        .clr_idx    (clr_idx),
        .clr_active (clr_active),
        .clr_done   (clr_done)
    );

    ////////////////////////////////////////
    // Scoreboard and storage

    rf_inuse inuse_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .clr_active (clr_active),
        .clr_idx    (clr_idx),
        .ready      (ready),
        .issue      (issue),
        .issue_rd   (issue_rd),
        .wb_match   (wb_match),
        .wb_rd      (wb_rd),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_inuse  (rs1_inuse),
        .rs2_inuse  (rs2_inuse)
    );

    rf_regs #(
        .XLEN (XLEN),
        .ID_W (ID_W)
    ) regs_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .clr_active   (clr_active),
        .clr_all      (clr_all),
        .clr_idx      (clr_idx),
        .ready        (ready),
        .issue        (issue),
        .issue_rd     (issue_rd),
        .issue_id     (issue_id),
        .wb_commit    (wb_commit),
        .wb_rd        (wb_rd),
        .wb_id        (wb_id),
        .wb_data      (wb_data),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .uses_rs1     (uses_rs1),
        .uses_rs2     (uses_rs2),
        .rs1_inuse    (rs1_inuse),
        .rs2_inuse    (rs2_inuse),
        .dbg_addr     (dbg_addr),
        .dbg_data     (dbg_data),
        .wb_match     (wb_match),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rs1_conflict (rs1_conflict),
        .rs2_conflict (rs2_conflict)
    );

    ////////////////////////////////////////
    // Debug port

    rf_wb_debug #(
        .XLEN (XLEN)
    ) wb_debug_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .dbg_addr (dbg_addr),
        .dbg_data (dbg_data)
    );

endmodule

// ==== rf_core_sva.sv ====
////////////////////////////////////////
// Register file assertions
// Wishbone ack and clear sequencer rules
////////////////////////////////////////

module rf_core_sva (
    input logic clk,
    input logic rst_n,
    input logic flush,
    input logic ready,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic rs1_conflict,
    input logic rs2_conflict
);
    timeunit 1ns;
    timeprecision 1ps;

    // Never two acks in a row
    ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high for two cycles");

    // Ack answers a request from the cycle before
    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack without a request");

    // No stall reported during a clear
    no_conflict_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !ready |-> !rs1_conflict && !rs2_conflict)
        else $error("conflict raised while ready is low");

    // ready only drops after a flush pulse
    ready_fall_flush: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(ready) |-> $past(flush))
        else $error("ready fell without a flush");

endmodule

bind rf_core_top rf_core_sva sva_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),
    .ready        (ready),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_ack       (wb_ack),
    .rs1_conflict (rs1_conflict),
    .rs2_conflict (rs2_conflict)
);

// ==== tb_rf_core.sv ====
////////////////////////////////////////
// Register file testbench
// Directed and random checks against a scoreboard model
////////////////////////////////////////

module tb_rf_core;
    timeunit 1ns;
    timeprecision 1ps;
    import rf_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int CLEAR_CYCLES = 34;
    localparam int RAND_CYCLES  = 300;
    // Decode sweeps plus debug reads at two cycles each
    localparam int DIRECTED_CYCLES = 3 * NUM_REGS + 4 * NUM_REGS + 60;
    localparam int TEST_CYCLES = RESET_CYCLES + 2 * CLEAR_CYCLES + DIRECTED_CYCLES
                                 + 2 * RAND_CYCLES;
    localparam int TIMEOUT_NS = TEST_CYCLES * CLK_PERIOD + 400;

    logic      clk;
    logic      rst_n;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    logic      uses_rs1;
    logic      uses_rs2;
    logic      issue;
    reg_addr_t issue_rd;
    instr_id_t issue_id;
    reg_data_t rs1_data;
    reg_data_t rs2_data;
    logic      rs1_conflict;
    logic      rs2_conflict;
    logic      ready;
    logic      wb_commit;
    reg_addr_t wb_rd;
    instr_id_t wb_id;
    reg_data_t wb_data;
    logic      flush;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    reg_addr_t wb_adr;
    reg_data_t wb_dat_o;
    logic      wb_ack;

    // Scoreboard model
    reg_data_t m_regs  [NUM_REGS];
    logic      m_inuse [NUM_REGS];
    instr_id_t m_owner [NUM_REGS];

    // Outstanding writers for the random phase
    reg_addr_t pend_rd [$];
    instr_id_t pend_id [$];

    // Compare process state
    reg_data_t exp1_data;
    reg_data_t exp2_data;
    logic      exp1_conf;
    logic      exp2_conf;
    logic      dbg_pend;
    logic      dbg_chk;
    reg_data_t dbg_exp;

    integer seed;

    rf_core_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .uses_rs1     (uses_rs1),
        .uses_rs2     (uses_rs2),
        .issue        (issue),
        .issue_rd     (issue_rd),
        .issue_id     (issue_id),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rs1_conflict (rs1_conflict),
        .rs2_conflict (rs2_conflict),
        .ready        (ready),
        .wb_commit    (wb_commit),
        .wb_rd        (wb_rd),
        .wb_id        (wb_id),
        .wb_data      (wb_data),
        .flush        (flush),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_o     (wb_dat_o),
        .wb_ack       (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // Error reporting and compare tasks

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("Mismatch at %0t ns: %s got 0x%h expected 0x%h",
                                      $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("Mismatch at %0t ns: %s got %b expected %b",
                                      $time, name, got, exp));
        end
    endtask

    ////////////////////////////////////////
    // Reference model

    // Expected read data and stall for one source before this cycle's edge
    function automatic void ref_source(input reg_addr_t a, input logic uses,
                                       output reg_data_t data, output logic conflict);
        logic busy;
        logic owned;
        logic fwd;
        busy  = (a != '0) && m_inuse[a];
        owned = wb_commit && (wb_rd != '0) && (wb_id == m_owner[wb_rd]);
        fwd   = busy && owned && (wb_rd == a);
        data     = fwd ? wb_data : m_regs[a];
        conflict = uses && busy && !fwd;
    endfunction

    // Effect of the current inputs at the next edge
    task automatic update_model;
        if (wb_commit && wb_rd != '0) begin
            if (wb_id == m_owner[wb_rd]) begin
                m_inuse[wb_rd] = 1'b0;
            end
            m_regs[wb_rd] = wb_data;
        end
        // Issue after commit so the same register stays busy
        if (issue && issue_rd != '0) begin
            m_inuse[issue_rd] = 1'b1;
            m_owner[issue_rd] = issue_id;
        end
        if (flush) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                m_inuse[i] = 1'b0;
            end
        end
    endtask

    ////////////////////////////////////////
    // Compare process at mid-cycle

    always @(negedge clk) begin
        if (rst_n && ready) begin
            ref_source(rs1_addr, uses_rs1, exp1_data, exp1_conf);
            ref_source(rs2_addr, uses_rs2, exp2_data, exp2_conf);
            check_data("rs1_data", rs1_data, exp1_data);
            check_data("rs2_data", rs2_data, exp2_data);
            check_flag("rs1_conflict", rs1_conflict, exp1_conf);
            check_flag("rs2_conflict", rs2_conflict, exp2_conf);
            if (rs1_addr == '0) begin
                check_data("rs1_data at x0", rs1_data, '0);
            end
        end else if (rst_n) begin
            // Conflicts held low during a clear
            check_flag("rs1_conflict", rs1_conflict, 1'b0);
            check_flag("rs2_conflict", rs2_conflict, 1'b0);
        end
        // Wishbone ack exactly one cycle after each request
        if (dbg_pend) begin
            if (!wb_ack) begin
                stop_with_error("Wishbone ack missing one cycle after the request");
            end
            if (dbg_chk) begin
                check_data("wb_dat_o", wb_dat_o, dbg_exp);
            end
            dbg_pend = 1'b0;
        end else if (wb_ack) begin
            stop_with_error("Wishbone ack seen without a request");
        end
        if (wb_cyc && wb_stb && !wb_ack) begin
            dbg_pend = 1'b1;
            dbg_chk  = ready && !wb_we;
            dbg_exp  = m_regs[wb_adr];
        end
        if (rst_n && ready) begin
            update_model();
        end
    end

    ////////////////////////////////////////
    // Stimulus helpers

    task automatic drive_idle;
        issue     = 1'b0;
        issue_rd  = '0;
        issue_id  = '0;
        wb_commit = 1'b0;
        wb_rd     = '0;
        wb_id     = '0;
        wb_data   = '0;
        flush     = 1'b0;
    endtask

    task automatic wait_ready(input int expected);
        int n;
        n = 0;
        while (!ready && n < CLEAR_CYCLES + 8) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!ready) begin
            stop_with_error("ready never rose after the clear sequence");
        end else if (n != expected) begin
            stop_with_error($sformatf("ready rose after %0d cycles instead of %0d", n, expected));
        end
    endtask

    task automatic run_flush;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        wait_ready(CLEAR_CYCLES - 1);
    endtask

    // Drop the request once acked
    task automatic end_debug_cycle;
        int n;
        n = 0;
        while (wb_cyc && !wb_ack && n < 8) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (wb_cyc && !wb_ack) begin
            stop_with_error("Wishbone ack never arrived");
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic debug_read(input reg_addr_t a, input reg_data_t exp);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = a;
        @(posedge clk);
        #1;
        end_debug_cycle();
        check_data("wb_dat_o", wb_dat_o, exp);
    endtask

    // Check source 1 mid-cycle and step to the next drive point
    task automatic expect_rs1(input reg_data_t exp_data, input logic exp_conf);
        @(negedge clk);
        check_data("rs1_data", rs1_data, exp_data);
        check_flag("rs1_conflict", rs1_conflict, exp_conf);
        @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////
    // Watchdog

    initial begin
        #(TIMEOUT_NS);
        stop_with_error("Timeout: the run did not finish in time");
    end

    ////////////////////////////////////////
    // Main sequence

    initial begin
        reg_data_t exp_val;
        instr_id_t next_id;
        reg_addr_t rd;
        int        pick;
        seed = 24533;
        for (int i = 0; i < NUM_REGS; i++) begin
            m_regs[i]  = '0;
            m_inuse[i] = 1'b0;
            m_owner[i] = '0;
        end
        dbg_pend = 1'b0;
        dbg_chk  = 1'b0;
        dbg_exp  = '0;
        rst_n    = 1'b0;
        rs1_addr = '0;
        rs2_addr = '0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        drive_idle();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Full clear after reset
        wait_ready(CLEAR_CYCLES);
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        for (int r = 0; r < NUM_REGS; r++) begin
            rs1_addr = reg_addr_t'(r);
            rs2_addr = reg_addr_t'(NUM_REGS - 1 - r);
            @(negedge clk);
            check_data("rs1_data", rs1_data, '0);
            check_data("rs2_data", rs2_data, '0);
            check_flag("rs1_conflict", rs1_conflict, 1'b0);
            check_flag("rs2_conflict", rs2_conflict, 1'b0);
            @(posedge clk);
            #1;
        end
        for (int r = 0; r < NUM_REGS; r++) begin
            debug_read(reg_addr_t'(r), '0);
        end

        // Issue, stall, bypass in the commit cycle, then stored value
        rs1_addr = 5'd5;
        issue    = 1'b1;
        issue_rd = 5'd5;
        issue_id = 3'd3;
        expect_rs1('0, 1'b0);
        issue = 1'b0;
        expect_rs1('0, 1'b1);
        expect_rs1('0, 1'b1);
        wb_commit = 1'b1;
        wb_rd     = 5'd5;
        wb_id     = 3'd3;
        wb_data   = 32'hcafe_0005;
        expect_rs1(32'hcafe_0005, 1'b0);
        wb_commit = 1'b0;
        expect_rs1(32'hcafe_0005, 1'b0);
        debug_read(5'd5, 32'hcafe_0005);

        // Stale id writes the value but keeps the stall
        rs1_addr = 5'd7;
        issue    = 1'b1;
        issue_rd = 5'd7;
        issue_id = 3'd1;
        expect_rs1('0, 1'b0);
        issue_id = 3'd2;
        expect_rs1('0, 1'b1);
        issue     = 1'b0;
        wb_commit = 1'b1;
        wb_rd     = 5'd7;
        wb_id     = 3'd1;
        wb_data   = 32'h0000_1111;
        expect_rs1('0, 1'b1);
        wb_commit = 1'b0;
        expect_rs1(32'h0000_1111, 1'b1);
        wb_commit = 1'b1;
        wb_id     = 3'd2;
        wb_data   = 32'h0000_2222;
        expect_rs1(32'h0000_2222, 1'b0);
        wb_commit = 1'b0;
        expect_rs1(32'h0000_2222, 1'b0);

        // Flush with x9 still pending
        rs1_addr = 5'd9;
        issue    = 1'b1;
        issue_rd = 5'd9;
        issue_id = 3'd4;
        expect_rs1('0, 1'b0);
        issue = 1'b0;
        expect_rs1('0, 1'b1);
        run_flush();
        for (int r = 0; r < NUM_REGS; r++) begin
            exp_val = (r == 5) ? 32'hcafe_0005 : (r == 7) ? 32'h0000_2222 : '0;
            rs1_addr = reg_addr_t'(r);
            expect_rs1(exp_val, 1'b0);
        end
        debug_read(5'd5, 32'hcafe_0005);
        debug_read(5'd7, 32'h0000_2222);

        // Random phase
        next_id = 3'd5;
        for (int c = 0; c < RAND_CYCLES; c++) begin
            issue     = 1'b0;
            wb_commit = 1'b0;
            rs1_addr  = reg_addr_t'($random(seed));
            rs2_addr  = reg_addr_t'($random(seed));
            uses_rs1  = $random(seed) & 1;
            uses_rs2  = $random(seed) & 1;
            // Commit picked before the new issue is queued
            if (pend_rd.size() > 0 && ($random(seed) & 3) != 0) begin
                pick      = ($random(seed) & 32'h7fff) % pend_rd.size();
                wb_commit = 1'b1;
                wb_rd     = pend_rd[pick];
                wb_id     = pend_id[pick];
                wb_data   = reg_data_t'($random(seed));
                pend_rd.delete(pick);
                pend_id.delete(pick);
            end
            if (pend_rd.size() < 8 && ($random(seed) & 1) != 0) begin
                rd       = reg_addr_t'($random(seed));
                issue    = 1'b1;
                issue_rd = rd;
                issue_id = next_id;
                next_id  = instr_id_t'(next_id + 1);
                if (rd != '0) begin
                    pend_rd.push_back(rd);
                    pend_id.push_back(issue_id);
                end
            end
            if (wb_cyc && wb_ack) begin
                wb_cyc = 1'b0;
                wb_stb = 1'b0;
            end else if (!wb_cyc && ($random(seed) & 3) == 0) begin
                wb_cyc = 1'b1;
                wb_stb = 1'b1;
                wb_we  = ($random(seed) & 7) == 0;
                wb_adr = reg_addr_t'($random(seed));
            end
            @(posedge clk);
            #1;
        end
        drive_idle();
        end_debug_cycle();
        repeat (3) @(posedge clk);
        #1;
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== rf_core.f ====
rf_pkg.sv
rf_clear_counter.sv
rf_init_fsm.sv
rf_inuse.sv
rf_regs.sv
rf_wb_debug.sv
rf_core_top.sv
rf_core_sva.sv
tb_rf_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0
TOP       = tb_rf_core
FILELIST  = rf_core.f
BUILD     = obj_dir
LOG       = sim.log
FAIL_MSG  = FAIL: see errors above
PASS_MSG  = PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
